//--- compile.f
core_pkg.sv
pc_counter.sv
ctrl_fsm.sv
idu.sv
regfile.sv
exu.sv
core_top.sv
tb_core.sv

//--- Bender.yml
package:
  name: rv32i_mini_core

sources:
  - files:
      - core_pkg.sv
      - pc_counter.sv
      - ctrl_fsm.sv
      - idu.sv
      - regfile.sv
      - exu.sv
      - core_top.sv
  - target: test
    files:
      - tb_core.sv

//--- tb_core.sv
module tb_core;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD   = 100;
    localparam int DRIVE_DELAY  = 5;
    localparam int RESET_CYCLES = 16;
    localparam int HALT_HOLD    = 20;
    localparam int PROG_LEN     = 201;  // 200 random instructions and the closing ebreak
    localparam int EBREAK_ADDR  = 4 * (PROG_LEN - 1);
    localparam int HALT_CYCLE   = 3 * (PROG_LEN - 1) + 3;
    localparam int WATCHDOG_NS  = (RESET_CYCLES + (PROG_LEN + 10) * 3 + HALT_HOLD) * CLK_PERIOD;

    localparam int T_RESET = 0;
    localparam int T_WB    = 1;
    localparam int T_PC    = 2;
    localparam int T_HALT  = 3;

    logic        clk;
    logic        arst_n;
    logic [31:0] inst;
    logic [31:0] inst_addr;
    logic        wb_en;
    logic [4:0]  wb_addr;
    logic [31:0] wb_data;
    logic        halted;
    logic [31:0] instret;

    integer      seed = 32'hb4cd_07f0;
    logic [31:0] imem [0:PROG_LEN-1];
    logic [31:0] model_regs [0:31];
    logic [4:0]  exp_addr_q [$];
    logic [31:0] exp_data_q [$];

    int    errs [0:3] = '{default: 0};
    string test_names [0:3] = '{"reset", "write-back", "pc and instret", "halt"};

    bit          started;
    bit          halt_seen;
    int          cycle;
    int          last_change;
    int          halt_cycle;
    int          retired;
    logic [31:0] last_addr;

    core_top UUT (
        .clk       (clk),
        .arst_n    (arst_n),
        .inst      (inst),
        .inst_addr (inst_addr),
        .wb_en     (wb_en),
        .wb_addr   (wb_addr),
        .wb_data   (wb_data),
        .halted    (halted),
        .instret   (instret)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual, input int test_id);
        assert (actual === expected) else begin
            errs[test_id]++;
            $display("ERR %s expected %h actual %h at %0t", name, expected, actual, $time);
        end
    endtask

    task automatic report_failure(input string msg, input int test_id);
        errs[test_id]++;
        $display("error in %s test at %0t: %s", test_names[test_id], $time, msg);
    endtask

    task automatic report_test(input int test_id);
        if (errs[test_id] == 0) begin
            $display("test %s: ok", test_names[test_id]);
        end else begin
            $display("test %s: failed with %0d errors", test_names[test_id], errs[test_id]);
        end
    endtask

    function automatic logic [31:0] read_imem(input logic [31:0] addr);
        int idx;
        idx = int'(addr >> 2);
        if (addr[1:0] != 2'b00 || idx >= PROG_LEN) begin
            return 32'h0000_0000;  // opcode zero decodes as unknown
        end
        return imem[idx];
    endfunction

    task automatic gen_program();
        logic [31:0] r;
        logic [31:0] r2;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] imm;
        for (int i = 0; i < PROG_LEN - 1; i++) begin
            r   = $random(seed);
            r2  = $random(seed);
            rd  = {1'b0, r[3:0]};  // x0..x15 keeps plenty of dependencies and x0 writes
            rs1 = {1'b0, r[7:4]};
            rs2 = {1'b0, r[11:8]};
            imm = r2[11:0];
            case (r[15:12])
                4'd0, 4'd1, 4'd14: imem[i] = {imm, rs1, 3'b000, rd, core_pkg::OPC_OP_IMM};
                4'd2:  imem[i] = {imm, rs1, 3'b111, rd, core_pkg::OPC_OP_IMM};
                4'd3:  imem[i] = {imm, rs1, 3'b110, rd, core_pkg::OPC_OP_IMM};
                4'd4:  imem[i] = {imm, rs1, 3'b100, rd, core_pkg::OPC_OP_IMM};
                4'd5, 4'd6: imem[i] = {7'b0000000, rs2, rs1, 3'b000, rd, core_pkg::OPC_OP};
                4'd7, 4'd8: imem[i] = {7'b0100000, rs2, rs1, 3'b000, rd, core_pkg::OPC_OP};
                4'd9, 4'd10, 4'd11: imem[i] = {r2[31:12], rd, core_pkg::OPC_LUI};
                default: begin
                    // lw, slli, mul and ecall all fall outside the supported set
                    case (r[17:16])
                        2'd0: imem[i] = {imm, rs1, 3'b010, rd, 7'b0000011};
                        2'd1: imem[i] = {7'b0000000, rs2, rs1, 3'b001, rd, core_pkg::OPC_OP_IMM};
                        2'd2: imem[i] = {7'b0000001, rs2, rs1, 3'b000, rd, core_pkg::OPC_OP};
                        default: imem[i] = 32'h0000_0073;
                    endcase
                end
            endcase
        end
        imem[PROG_LEN-1] = 32'h0010_0073;  // ebreak
    endtask

    task automatic model_step(input logic [31:0] w);
        logic [6:0]  opc;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [4:0]  rd;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] res;
        logic        wr;
        opc   = w[6:0];
        f3    = w[14:12];
        f7    = w[31:25];
        rd    = w[11:7];
        a     = model_regs[w[19:15]];
        b     = model_regs[w[24:20]];
        imm_i = {{20{w[31]}}, w[31:20]};
        wr    = 1'b1;
        res   = '0;
        if (opc == core_pkg::OPC_OP_IMM && f3 == 3'b000) res = a + imm_i;
        else if (opc == core_pkg::OPC_OP_IMM && f3 == 3'b111) res = a & imm_i;
        else if (opc == core_pkg::OPC_OP_IMM && f3 == 3'b110) res = a | imm_i;
        else if (opc == core_pkg::OPC_OP_IMM && f3 == 3'b100) res = a ^ imm_i;
        else if (opc == core_pkg::OPC_OP && f3 == 3'b000 && f7 == 7'b0000000) res = a + b;
        else if (opc == core_pkg::OPC_OP && f3 == 3'b000 && f7 == 7'b0100000) res = a - b;
        else if (opc == core_pkg::OPC_LUI) res = {w[31:12], 12'h000};
        else wr = 1'b0;
        if (wr && rd != 5'd0) begin
            model_regs[rd] = res;
            exp_addr_q.push_back(rd);
            exp_data_q.push_back(res);
        end
    endtask

    task automatic check_reset_values();
        check_value("wb_en", 32'd0, wb_en, T_RESET);
        check_value("halted", 32'd0, halted, T_RESET);
        check_value("inst_addr", 32'd0, inst_addr, T_RESET);
        check_value("instret", 32'd0, instret, T_RESET);
    endtask

    task automatic check_writeback();
        logic [4:0]  exp_addr;
        logic [31:0] exp_data;
        assert (wb_addr != 5'd0) else report_failure("write-back strobe addressed to x0", T_WB);
        assert (exp_addr_q.size() > 0) else
            report_failure($sformatf("write-back to x%0d with none expected", wb_addr), T_WB);
        if (exp_addr_q.size() > 0) begin
            exp_addr = exp_addr_q.pop_front();
            exp_data = exp_data_q.pop_front();
            check_value("wb_addr", exp_addr, wb_addr, T_WB);
            check_value("wb_data", exp_data, wb_data, T_WB);
        end
    endtask

    always @(posedge clk) begin
        #(DRIVE_DELAY);
        inst = read_imem(inst_addr);
    end

    // outputs are sampled on the falling edge, half a period away from any update
    always @(negedge clk) begin
        if (arst_n) begin
            if (!started) begin
                started     = 1'b1;
                cycle       = 0;
                last_change = 0;
                last_addr   = inst_addr;
            end else begin
                cycle++;
            end
            if (wb_en) check_writeback();
            if (inst_addr !== last_addr) begin
                check_value("inst_addr", last_addr + 32'd4, inst_addr, T_PC);
                assert (cycle - last_change == 3) else
                    report_failure($sformatf("pc moved after %0d cycles instead of 3",
                                             cycle - last_change), T_PC);
                retired++;
                check_value("instret", retired, instret, T_PC);
                last_addr   = inst_addr;
                last_change = cycle;
            end
            if (halted && !halt_seen) begin
                halt_cycle = cycle;
                halt_seen  = 1'b1;
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("run timed out after %0d ns before the checks finished", WATCHDOG_NS);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        int failed;
        clk    = 1'b0;
        arst_n = 1'b0;
        inst   = '0;
        for (int i = 0; i < 32; i++) model_regs[i] = '0;
        gen_program();
        for (int i = 0; i < PROG_LEN - 1; i++) model_step(imem[i]);
        $display("program of %0d words, %0d write-backs expected", PROG_LEN, exp_addr_q.size());

        repeat (RESET_CYCLES - 1) @(posedge clk);
        @(negedge clk);
        check_reset_values();
        @(posedge clk);
        #(DRIVE_DELAY) arst_n = 1'b1;
        @(negedge clk);
        check_reset_values();  // first fetch cycle, nothing has moved yet
        report_test(T_RESET);

        wait (halt_seen);
        assert (halt_cycle == HALT_CYCLE) else
            report_failure($sformatf("halted rose in cycle %0d, expected cycle %0d",
                                     halt_cycle, HALT_CYCLE), T_HALT);
        assert (exp_addr_q.size() == 0) else
            report_failure($sformatf("%0d expected write-backs never appeared",
                                     exp_addr_q.size()), T_WB);
        check_value("instret", PROG_LEN - 1, instret, T_PC);
        report_test(T_WB);
        report_test(T_PC);

        check_value("inst_addr", EBREAK_ADDR, inst_addr, T_HALT);
        repeat (HALT_HOLD) begin
            @(negedge clk);
            check_value("wb_en", 32'd0, wb_en, T_HALT);
            check_value("inst_addr", EBREAK_ADDR, inst_addr, T_HALT);
            check_value("halted", 32'd1, halted, T_HALT);
        end
        report_test(T_HALT);

        failed = 0;
        for (int i = 0; i < 4; i++) begin
            if (errs[i] != 0) failed++;
        end
        $display("summary: %0d ok, %0d failing out of 4 tests", 4 - failed, failed);
        if (failed == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- core_top.sv
module core_top (
    input  logic                            clk,
    input  logic                            arst_n,
    input  logic [core_pkg::XLEN-1:0]       inst,
    output logic [core_pkg::XLEN-1:0]       inst_addr,
    output logic                            wb_en,
    output logic [core_pkg::REG_ADDR_W-1:0] wb_addr,
    output logic [core_pkg::XLEN-1:0]       wb_data,
    output logic                            halted,
    output logic [core_pkg::XLEN-1:0]       instret
);

    logic fetch_en;
    logic decode_en;
    logic exec_en;
    logic halt_req;

    logic [core_pkg::XLEN-1:0] ir;  // instruction register

    logic [core_pkg::REG_ADDR_W-1:0] rs1_addr;
    logic [core_pkg::REG_ADDR_W-1:0] rs2_addr;
    logic [core_pkg::XLEN-1:0]       rdata1;
    logic [core_pkg::XLEN-1:0]       rdata2;
    logic [core_pkg::XLEN-1:0]       src1;
    logic [core_pkg::XLEN-1:0]       src2;
    logic [core_pkg::REG_ADDR_W-1:0] rd;
    core_pkg::exu_op_e               op;

    // the instruction port answers in the same cycle, so fetch is one load
    always_ff @(posedge clk) begin
        if (fetch_en) begin
            ir <= inst;
        end
    end

    ctrl_fsm u_ctrl_fsm (
        .clk       (clk),
        .arst_n    (arst_n),
        .halt_req  (halt_req),
        .fetch_en  (fetch_en),
        .decode_en (decode_en),
        .exec_en   (exec_en),
        .halted    (halted)
    );

    pc_counter u_pc_counter (
        .clk      (clk),
        .arst_n   (arst_n),
        .exec_en  (exec_en),
        .halt_req (halt_req),
        .pc       (inst_addr),
        .instret  (instret)
    );

    idu u_idu (
        .clk       (clk),
        .arst_n    (arst_n),
        .decode_en (decode_en),
        .inst      (ir),
        .rdata1    (rdata1),
        .rdata2    (rdata2),
        .rs1_addr  (rs1_addr),
        .rs2_addr  (rs2_addr),
        .src1      (src1),
        .src2      (src2),
        .rd        (rd),
        .op        (op)
    );

    regfile u_regfile (
        .clk      (clk),
        .arst_n   (arst_n),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .we       (wb_en),
        .waddr    (wb_addr),
        .wdata    (wb_data),
        .rdata1   (rdata1),
        .rdata2   (rdata2)
    );

    exu u_exu (
        .clk      (clk),
        .arst_n   (arst_n),
        .exec_en  (exec_en),
        .op       (op),
        .src1     (src1),
        .src2     (src2),
        .rd       (rd),
        .wb_en    (wb_en),
        .wb_addr  (wb_addr),
        .wb_data  (wb_data),
        .halt_req (halt_req)
    );

endmodule

//--- exu.sv
module exu (
    input  logic                            clk,
    input  logic                            arst_n,
    input  logic                            exec_en,
    input  core_pkg::exu_op_e               op,
    input  logic [core_pkg::XLEN-1:0]       src1,
    input  logic [core_pkg::XLEN-1:0]       src2,
    input  logic [core_pkg::REG_ADDR_W-1:0] rd,
    output logic                            wb_en,
    output logic [core_pkg::REG_ADDR_W-1:0] wb_addr,
    output logic [core_pkg::XLEN-1:0]       wb_data,
    output logic                            halt_req
);

    logic [core_pkg::XLEN-1:0] alu_result;
    logic                      writes;

    always_comb begin
        case (op)
            core_pkg::OP_ADD:  alu_result = src1 + src2;
            core_pkg::OP_SUB:  alu_result = src1 - src2;
            core_pkg::OP_AND:  alu_result = src1 & src2;
            core_pkg::OP_OR:   alu_result = src1 | src2;
            core_pkg::OP_XOR:  alu_result = src1 ^ src2;
            core_pkg::OP_PASS: alu_result = src2;
            default:           alu_result = '0;  // nop and halt produce nothing
        endcase
    end

    assign writes = (op != core_pkg::OP_NOP) && (op != core_pkg::OP_HALT);

    // combinational so the controller and the pc see it in the same exec cycle
    assign halt_req = exec_en && (op == core_pkg::OP_HALT);

    // the strobe lands in the cycle after exec, three cycles after the fetch,
    // and the register file takes the data on the edge that closes that cycle
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_en <= 1'b0;
        end else begin
            wb_en <= exec_en && writes;
        end
    end

    always_ff @(posedge clk) begin
        if (exec_en) begin
            wb_addr <= rd;
            wb_data <= alu_result;
        end
    end

endmodule

//--- regfile.sv
module regfile (
    input  logic                            clk,
    input  logic                            arst_n,
    input  logic [core_pkg::REG_ADDR_W-1:0] rs1_addr,
    input  logic [core_pkg::REG_ADDR_W-1:0] rs2_addr,
    input  logic                            we,
    input  logic [core_pkg::REG_ADDR_W-1:0] waddr,
    input  logic [core_pkg::XLEN-1:0]       wdata,
    output logic [core_pkg::XLEN-1:0]       rdata1,
    output logic [core_pkg::XLEN-1:0]       rdata2
);

    // x0 has no storage
    logic [core_pkg::XLEN-1:0] regs [1:core_pkg::NUM_REGS-1];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < core_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rdata2 = (rs2_addr == '0) ? '0 : regs[rs2_addr];

    // the decoder turns every x0 destination into a no-op before it gets here
    no_write_to_x0: assert property (
        @(posedge clk) disable iff (!arst_n)
        we |-> (waddr != '0)
    );

endmodule

//--- idu.sv
module idu (
    input  logic                            clk,
    input  logic                            arst_n,
    input  logic                            decode_en,
    input  logic [core_pkg::XLEN-1:0]       inst,
    input  logic [core_pkg::XLEN-1:0]       rdata1,
    input  logic [core_pkg::XLEN-1:0]       rdata2,
    output logic [core_pkg::REG_ADDR_W-1:0] rs1_addr,
    output logic [core_pkg::REG_ADDR_W-1:0] rs2_addr,
    output logic [core_pkg::XLEN-1:0]       src1,
    output logic [core_pkg::XLEN-1:0]       src2,
    output logic [core_pkg::REG_ADDR_W-1:0] rd,
    output core_pkg::exu_op_e               op
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic [core_pkg::REG_ADDR_W-1:0] rd_field;

    logic [core_pkg::XLEN-1:0] imm_i;
    logic [core_pkg::XLEN-1:0] imm_u;

    core_pkg::exu_op_e dec_op;
    logic is_imm;
    logic is_reg;
    logic is_lui;
    logic known;
    logic reg1_ren;
    logic reg2_ren;
    logic wreg_ren;

    logic [core_pkg::REG_ADDR_W-1:0] rd_next;
    core_pkg::exu_op_e               op_next;
    logic [core_pkg::XLEN-1:0]       src2_next;

    assign opcode   = inst[6:0];
    assign funct3   = inst[14:12];
    assign funct7   = inst[31:25];
    assign rd_field = inst[11:7];

    assign imm_i = {{(core_pkg::XLEN-12){inst[31]}}, inst[31:20]};
    assign imm_u = {inst[31:12], 12'b0};

    always_comb begin
        dec_op = core_pkg::OP_NOP;
        case (opcode)
            core_pkg::OPC_OP_IMM: begin
                case (funct3)
                    core_pkg::F3_ADD_SUB: dec_op = core_pkg::OP_ADD;
                    core_pkg::F3_XOR:     dec_op = core_pkg::OP_XOR;
                    core_pkg::F3_OR:      dec_op = core_pkg::OP_OR;
                    core_pkg::F3_AND:     dec_op = core_pkg::OP_AND;
                    default:              dec_op = core_pkg::OP_NOP;  // shifts, slti
                endcase
            end
            core_pkg::OPC_OP: begin
                if (funct3 == core_pkg::F3_ADD_SUB && funct7 == core_pkg::F7_BASE) begin
                    dec_op = core_pkg::OP_ADD;
                end else if (funct3 == core_pkg::F3_ADD_SUB && funct7 == core_pkg::F7_SUB) begin
                    dec_op = core_pkg::OP_SUB;
                end
            end
            core_pkg::OPC_LUI:    dec_op = core_pkg::OP_PASS;
            core_pkg::OPC_SYSTEM: begin
                if (inst == core_pkg::EBREAK_INST) begin
                    dec_op = core_pkg::OP_HALT;
                end
            end
            default:              dec_op = core_pkg::OP_NOP;
        endcase
    end

    assign is_imm = (opcode == core_pkg::OPC_OP_IMM);
    assign is_reg = (opcode == core_pkg::OPC_OP);
    assign is_lui = (opcode == core_pkg::OPC_LUI);
    assign known  = (dec_op != core_pkg::OP_NOP);

    // an unused read port is parked on x0, which reads as zero
    assign reg1_ren = known && (is_imm || is_reg);
    assign reg2_ren = known && is_reg;
    assign rs1_addr = reg1_ren ? inst[19:15] : '0;
    assign rs2_addr = reg2_ren ? inst[24:20] : '0;

    // writes to x0 become no-ops here, nothing downstream filters them again
    assign wreg_ren = known && (dec_op != core_pkg::OP_HALT) && (rd_field != '0);
    assign rd_next  = wreg_ren ? rd_field : '0;
    assign op_next  = (wreg_ren || dec_op == core_pkg::OP_HALT) ? dec_op : core_pkg::OP_NOP;

    assign src2_next = is_reg ? rdata2 : (is_lui ? imm_u : imm_i);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd <= '0;
            op <= core_pkg::OP_NOP;
        end else if (decode_en) begin
            rd <= rd_next;
            op <= op_next;
        end
    end

    always_ff @(posedge clk) begin
        if (decode_en) begin
            src1 <= rdata1;  // zero whenever rs1 is unused
            src2 <= src2_next;
        end
    end

endmodule

//--- ctrl_fsm.sv
module ctrl_fsm (
    input  logic clk,
    input  logic arst_n,
    input  logic halt_req,
    output logic fetch_en,
    output logic decode_en,
    output logic exec_en,
    output logic halted
);

    core_pkg::ctrl_state_e state;
    core_pkg::ctrl_state_e state_next;

    always_comb begin
        state_next = state;
        case (state)
            core_pkg::S_FETCH:  state_next = core_pkg::S_DECODE;
            core_pkg::S_DECODE: state_next = core_pkg::S_EXEC;
            core_pkg::S_EXEC: begin
                // ebreak is seen while it executes, so halting costs no extra cycle
                state_next = halt_req ? core_pkg::S_HALT : core_pkg::S_FETCH;
            end
            core_pkg::S_HALT:   state_next = core_pkg::S_HALT;  // only reset leaves
            default:            state_next = core_pkg::S_FETCH;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state  <= core_pkg::S_FETCH;  // first fetch right after reset
            halted <= 1'b0;
        end else begin
            state  <= state_next;
            halted <= (state_next == core_pkg::S_HALT);
        end
    end

    assign fetch_en  = (state == core_pkg::S_FETCH);
    assign decode_en = (state == core_pkg::S_DECODE);
    assign exec_en   = (state == core_pkg::S_EXEC);

    // outside the halt exactly one step runs, and once halted no step runs
    one_step_per_cycle: assert property (
        @(posedge clk) disable iff (!arst_n)
        $onehot({fetch_en, decode_en, exec_en, halted})
    );

    halted_is_sticky: assert property (
        @(posedge clk) disable iff (!arst_n)
        halted |=> halted
    );

endmodule

//--- pc_counter.sv
module pc_counter (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      exec_en,
    input  logic                      halt_req,
    output logic [core_pkg::XLEN-1:0] pc,
    output logic [core_pkg::XLEN-1:0] instret
);

    logic retire;

    // ebreak leaves the pc on its own address and does not count as retired
    assign retire = exec_en && !halt_req;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc      <= core_pkg::PC_RESET;
            instret <= '0;
        end else if (retire) begin
            pc      <= pc + core_pkg::PC_STEP;
            instret <= instret + 1'b1;  // no-ops count too
        end
    end

    // the pc only ever moves by whole words from an aligned reset value
    pc_word_aligned: assert property (
        @(posedge clk) disable iff (!arst_n)
        pc[1:0] == 2'b00
    );

endmodule

//--- core_pkg.sv
package core_pkg;

    // RV32I fixes all widths, so these stay localparams rather than module parameters
    localparam int unsigned XLEN       = 32;
    localparam int unsigned REG_ADDR_W = 5;
    localparam int unsigned NUM_REGS   = 2 ** REG_ADDR_W;

    localparam logic [XLEN-1:0] PC_RESET = '0;
    localparam logic [XLEN-1:0] PC_STEP  = 32'd4;  // every instruction is one word

    // major opcodes, bits [6:0]
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    // funct3 values of the supported ALU operations
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_SUB  = 7'b0100000;  // sets the sub bit of add

    // ebreak is matched on the whole word, so ecall and friends fall through as unknown
    localparam logic [XLEN-1:0] EBREAK_INST = 32'h0010_0073;

    // one state per step of the three-cycle instruction
    typedef enum logic [1:0] {
        S_FETCH  = 2'd0,
        S_DECODE = 2'd1,
        S_EXEC   = 2'd2,
        S_HALT   = 2'd3
    } ctrl_state_e;

    // operation handed from the decoder to the execute unit
    typedef enum logic [2:0] {
        OP_NOP  = 3'd0,  // retires without writing
        OP_ADD  = 3'd1,
        OP_SUB  = 3'd2,
        OP_AND  = 3'd3,
        OP_OR   = 3'd4,
        OP_XOR  = 3'd5,
        OP_PASS = 3'd6,  // lui passes the U immediate
        OP_HALT = 3'd7
    } exu_op_e;

endpackage
